//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] rv_word_t;
    typedef logic [31:0]     rv_inst_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    localparam rv_inst_t INST_ECALL = 32'h0000_0073;

endpackage

//--- hw/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        BR_BEQ, // branch compares only drive branch_taken
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } alu_op_t;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_t;

    typedef enum logic [1:0] {OP2_RS2, OP2_IMI, OP2_IMS} op2_sel_t;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC} wb_sel_t;

endpackage

//--- hw/rv_mem.sv
module rv_mem import rv_isa_pkg::*; #(
    parameter int  DEPTH  = 256,
    parameter type word_t = rv_word_t,
    localparam int AW     = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  word_t         wdata_i,
    input  logic [AW-1:0] raddr_a_i,
    output word_t         rdata_a_o,
    input  logic [AW-1:0] raddr_b_i,
    output word_t         rdata_b_o
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // both read ports are asynchronous
    assign rdata_a_o = mem[raddr_a_i];
    assign rdata_b_o = mem[raddr_b_i];

endmodule

//--- hw/rv_fetch.sv
module rv_fetch import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run_i,
    input  logic     halt_i,
    input  logic     redirect_i,
    input  rv_word_t target_i,
    output rv_word_t pc_o,
    output logic     running_o,
    output logic     halted_o
);

    rv_word_t pc_q;
    logic     running_q;
    logic     halted_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q      <= '0;
            running_q <= 1'b0;
            halted_q  <= 1'b0;
        end else if (running_q) begin
            if (halt_i) begin // ecall, pc stays put
                running_q <= 1'b0;
                halted_q  <= 1'b1;
            end else if (redirect_i) begin
                pc_q <= target_i;
            end else begin
                pc_q <= pc_q + rv_word_t'(4);
            end
        end else if (run_i) begin
            pc_q      <= '0;
            running_q <= 1'b1;
            halted_q  <= 1'b0;
        end
    end

    assign pc_o      = pc_q;
    assign running_o = running_q;
    assign halted_o  = halted_q;

endmodule

//--- hw/rv_decoder.sv
module rv_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  rv_inst_t                inst_i,
    output logic [REG_ADDR_W-1:0]   rs1_addr_o,
    output logic [REG_ADDR_W-1:0]   rs2_addr_o,
    output logic [REG_ADDR_W-1:0]   rd_addr_o,
    output rv_word_t                imm_i_o,
    output rv_word_t                imm_s_o,
    output rv_word_t                imm_b_o,
    output rv_word_t                imm_j_o,
    output alu_op_t                 alu_op_o,
    output op1_sel_t                op1_sel_o,
    output op2_sel_t                op2_sel_o,
    output logic                    rf_we_o,
    output logic                    mem_we_o,
    output wb_sel_t                 wb_sel_o,
    output logic                    is_branch_o,
    output logic                    is_jump_o,
    output logic                    halt_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       shift_f3;
    logic       f7_ok;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i_o = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign halt_o = (inst_i == INST_ECALL);

    // funct7 legality, alt encoding only for sub and sra
    assign shift_f3 = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);
    assign f7_ok    = (funct7 == F7_BASE) ||
                      (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: begin
                if (alt) arith_op = ALU_SUB;
                else     arith_op = ALU_ADD;
            end
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: begin
                if (alt) arith_op = ALU_SRA;
                else     arith_op = ALU_SRL;
            end
            F3_OR:      arith_op = ALU_OR;
            F3_AND:     arith_op = ALU_AND;
            default:    arith_op = ALU_ADD;
        endcase
    endfunction

    always_comb begin
        alu_op_o    = ALU_ADD;
        op1_sel_o   = OP1_RS1;
        op2_sel_o   = OP2_RS2;
        rf_we_o     = 1'b0;
        mem_we_o    = 1'b0;
        wb_sel_o    = WB_ALU;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        case (opcode)
            OPC_LOAD: if (funct3 == F3_LW) begin
                op2_sel_o = OP2_IMI;
                rf_we_o   = 1'b1;
                wb_sel_o  = WB_MEM;
            end
            OPC_STORE: if (funct3 == F3_SW) begin
                op2_sel_o = OP2_IMS;
                mem_we_o  = 1'b1;
            end
            OPC_OP: if (f7_ok) begin
                alu_op_o = arith_op(funct3, funct7 == F7_ALT);
                rf_we_o  = 1'b1;
            end
            OPC_OP_IMM: if (!shift_f3 || f7_ok) begin
                // addi with a high immediate must not turn into sub
                alu_op_o  = arith_op(funct3, shift_f3 && funct7 == F7_ALT);
                op2_sel_o = OP2_IMI;
                rf_we_o   = 1'b1;
            end
            OPC_BRANCH: begin
                is_branch_o = 1'b1;
                case (funct3)
                    F3_BEQ:  alu_op_o = BR_BEQ;
                    F3_BNE:  alu_op_o = BR_BNE;
                    F3_BLT:  alu_op_o = BR_BLT;
                    F3_BGE:  alu_op_o = BR_BGE;
                    F3_BLTU: alu_op_o = BR_BLTU;
                    F3_BGEU: alu_op_o = BR_BGEU;
                    default: is_branch_o = 1'b0;
                endcase
            end
            OPC_JAL: begin
                op1_sel_o = OP1_PC; // marks pc-relative jump
                rf_we_o   = 1'b1;
                wb_sel_o  = WB_PC;
                is_jump_o = 1'b1;
            end
            OPC_JALR: if (funct3 == F3_JALR) begin
                op2_sel_o = OP2_IMI;
                rf_we_o   = 1'b1;
                wb_sel_o  = WB_PC;
                is_jump_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/rv_regfile.sv
module rv_regfile import rv_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  rv_word_t              wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    output rv_word_t              rdata1_o,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output rv_word_t              rdata2_o
);

    localparam int NREGS = 2 ** REG_ADDR_W;

    rv_word_t regs [NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- hw/rv_alu.sv
module rv_alu import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  alu_op_t  alu_op_i,
    input  rv_word_t op1_i,
    input  rv_word_t op2_i,
    output rv_word_t result_o,
    output logic     branch_taken_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = op2_i[4:0];
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;
    assign eq    = op1_i == op2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = op1_i + op2_i;
            ALU_SUB:  result_o = op1_i - op2_i;
            ALU_AND:  result_o = op1_i & op2_i;
            ALU_OR:   result_o = op1_i | op2_i;
            ALU_XOR:  result_o = op1_i ^ op2_i;
            ALU_SLL:  result_o = op1_i << shamt;
            ALU_SRL:  result_o = op1_i >> shamt;
            ALU_SRA:  result_o = rv_word_t'($signed(op1_i) >>> shamt);
            ALU_SLT:  result_o = rv_word_t'(lt_s);
            ALU_SLTU: result_o = rv_word_t'(lt_u);
            default:  result_o = '0;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            BR_BEQ:  branch_taken_o = eq;
            BR_BNE:  branch_taken_o = !eq;
            BR_BLT:  branch_taken_o = lt_s;
            BR_BGE:  branch_taken_o = !lt_s; // signed >=
            BR_BLTU: branch_taken_o = lt_u;
            BR_BGEU: branch_taken_o = !lt_u;
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

//--- hw/rv_core.sv
module rv_core import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run_i,
    output rv_word_t pc_o,
    input  rv_inst_t inst_i,
    output rv_word_t dmem_addr_o,
    input  rv_word_t dmem_rdata_i,
    output logic     dmem_we_o,
    output rv_word_t dmem_wdata_o,
    output logic     running_o,
    output logic     halted_o
);

    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    rv_word_t imm_i, imm_s, imm_b, imm_j;
    rv_word_t rs1_data, rs2_data;
    rv_word_t op1, op2, alu_result, target, wb_data, pc_plus4;
    alu_op_t  alu_op;
    op1_sel_t op1_sel;
    op2_sel_t op2_sel;
    wb_sel_t  wb_sel;
    logic     rf_we, mem_we, is_branch, is_jump, halt, branch_taken;

    rv_fetch u_fetch (
        .clk, .rst_n, .run_i,
        .halt_i     (halt),
        .redirect_i (is_jump || (is_branch && branch_taken)),
        .target_i   (target),
        .pc_o,
        .running_o,
        .halted_o
    );

    rv_decoder u_decoder (
        .inst_i, .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
        .imm_i_o(imm_i), .imm_s_o(imm_s), .imm_b_o(imm_b), .imm_j_o(imm_j),
        .alu_op_o(alu_op), .op1_sel_o(op1_sel), .op2_sel_o(op2_sel),
        .rf_we_o(rf_we), .mem_we_o(mem_we), .wb_sel_o(wb_sel),
        .is_branch_o(is_branch), .is_jump_o(is_jump), .halt_o(halt)
    );

    rv_regfile u_regfile (
        .clk, .rst_n,
        .we_i(rf_we && running_o), .waddr_i(rd_addr), .wdata_i(wb_data),
        .raddr1_i(rs1_addr), .rdata1_o(rs1_data),
        .raddr2_i(rs2_addr), .rdata2_o(rs2_data)
    );

    rv_alu u_alu (
        .alu_op_i(alu_op), .op1_i(op1), .op2_i(op2),
        .result_o(alu_result), .branch_taken_o(branch_taken)
    );

    assign op1 = (op1_sel == OP1_PC) ? pc_o : rs1_data;

    always_comb begin
        case (op2_sel)
            OP2_IMI: op2 = imm_i;
            OP2_IMS: op2 = imm_s;
            default: op2 = rs2_data;
        endcase
    end

    assign pc_plus4 = pc_o + rv_word_t'(4);

    // jal is the only pc-relative jump
    always_comb begin
        if (is_branch)              target = pc_o + imm_b;
        else if (op1_sel == OP1_PC) target = pc_o + imm_j;
        else                        target = {alu_result[XLEN-1:1], 1'b0};
    end

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = dmem_rdata_i;
            WB_PC:   wb_data = pc_plus4; // link
            default: wb_data = alu_result;
        endcase
    end

    assign dmem_addr_o  = alu_result;
    assign dmem_we_o    = mem_we && running_o;
    assign dmem_wdata_o = rs2_data;

endmodule

//--- hw/rv_soc_top.sv
module rv_soc_top import rv_isa_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run_i,
    input  logic            load_we_i,
    input  logic            load_sel_i, // 0 imem, 1 dmem
    input  logic [XLEN-1:0] load_addr_i, // word index
    input  rv_word_t        load_data_i,
    input  logic [XLEN-1:0] peek_addr_i, // word index
    output rv_word_t        peek_data_o,
    output logic            running_o,
    output logic            halted_o
);

    localparam int IAW = $clog2(IMEM_WORDS);
    localparam int DAW = $clog2(DMEM_WORDS);

    rv_word_t pc, core_addr, core_wdata, dmem_rdata;
    rv_inst_t inst;
    logic     core_we, host_we;

    // host writes only land while the core is idle
    assign host_we = load_we_i && !running_o;

    rv_core u_core (
        .clk, .rst_n, .run_i,
        .pc_o(pc), .inst_i(inst),
        .dmem_addr_o(core_addr), .dmem_rdata_i(dmem_rdata),
        .dmem_we_o(core_we), .dmem_wdata_o(core_wdata),
        .running_o, .halted_o
    );

    rv_mem #(.DEPTH(IMEM_WORDS), .word_t(rv_inst_t)) u_imem (
        .clk,
        .we_i      (host_we && !load_sel_i),
        .waddr_i   (load_addr_i[IAW-1:0]),
        .wdata_i   (load_data_i),
        .raddr_a_i (pc[IAW+1:2]),
        .rdata_a_o (inst),
        .raddr_b_i ('0),
        .rdata_b_o ()
    );

    rv_mem #(.DEPTH(DMEM_WORDS), .word_t(rv_word_t)) u_dmem (
        .clk,
        .we_i      (core_we || (host_we && load_sel_i)),
        .waddr_i   (running_o ? core_addr[DAW+1:2] : load_addr_i[DAW-1:0]),
        .wdata_i   (running_o ? core_wdata : load_data_i),
        .raddr_a_i (core_addr[DAW+1:2]),
        .rdata_a_o (dmem_rdata),
        .raddr_b_i (peek_addr_i[DAW-1:0]),
        .rdata_b_o (peek_data_o)
    );

endmodule

//--- test/rv_soc_assertions.sv
module rv_soc_assertions import rv_isa_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     dmem_we_i,
    input rv_inst_t inst_i,
    input logic     running_i,
    input logic     halted_i,
    input rv_word_t pc_i
);

    int fail_count = 0; // failed assertions so far

    // data writes come only from a store while running
    a_we_running: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we_i |-> running_i && inst_i[6:0] == OPC_STORE)
        else begin
            fail_count++;
            $error("data memory write while idle or from a non-store");
        end

    a_state_excl: assert property (@(posedge clk) disable iff (!rst_n) !(halted_i && running_i))
        else begin
            fail_count++;
            $error("halted and running both high");
        end

    // fetch only ever adds 4 or takes an even target
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc not word aligned");
        end

endmodule

bind rv_core rv_soc_assertions u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .dmem_we_i (dmem_we_o),
    .inst_i    (inst_i),
    .running_i (running_o),
    .halted_i  (halted_o),
    .pc_i      (pc_o)
);

//--- test/tb_rv_soc.sv
module tb_rv_soc import rv_isa_pkg::*; ();

    localparam int TIMEOUT = 2000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     run;
    logic     load_we;
    logic     load_sel;
    logic     [XLEN-1:0] load_addr;
    rv_word_t load_data;
    logic     [XLEN-1:0] peek_addr;
    rv_word_t peek_data;
    logic     running;
    logic     halted;

    rv_inst_t prog[$];

    rv_soc_top #(.IMEM_WORDS(256), .DMEM_WORDS(256)) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run_i       (run),
        .load_we_i   (load_we),
        .load_sel_i  (load_sel),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .peek_addr_i (peek_addr),
        .peek_data_o (peek_data),
        .running_o   (running),
        .halted_o    (halted)
    );

    always #4 clk = ~clk;

    always @(u_dut.u_core.u_sva.fail_count) begin
        if (u_dut.u_core.u_sva.fail_count != 0) begin
            $display("assertion failure in the core");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end
    end

    function automatic rv_inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic rv_inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_inst_t store_inst(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, F3_SW, imm[4:0], OPC_STORE}; // base x0
    endfunction

    function automatic rv_inst_t load_inst(input logic [4:0] rd, input logic [11:0] imm);
        return i_type(imm, 5'd0, F3_LW, rd, OPC_LOAD);
    endfunction

    function automatic rv_inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic rv_inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // signed less-than from the sign bits
    function automatic logic less_signed(input rv_word_t a, input rv_word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    // reference model of the arithmetic ops
    function automatic rv_word_t model_op(input logic [2:0] f3, input logic alt,
                                          input rv_word_t a, input rv_word_t b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return less_signed(a, b) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return (alt && a[31]) ? ~(~a >> b[4:0]) : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic logic branch_rule(input logic [2:0] f3, input rv_word_t a,
                                         input rv_word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return less_signed(a, b);
            F3_BGE:  return !less_signed(a, b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare(input string name, input rv_word_t exp, input rv_word_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_word(input logic sel, input int addr, input rv_word_t data);
        @(negedge clk);
        load_we   = 1'b1;
        load_sel  = sel;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        load_we   = 1'b0;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            load_word(1'b0, i, prog[i]);
        end
    endtask

    // cycles counts falling edges after the edge that samples run
    task automatic run_and_wait(output int cycles);
        @(negedge clk);
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
        cycles = 0;
        while (!halted) begin
            if (cycles >= TIMEOUT) begin
                $display("core did not halt within %0d cycles", TIMEOUT);
                $display("STATUS: FAIL");
                $fatal(1, "halt timeout");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic verify_word(input string name, input int addr, input rv_word_t exp);
        @(negedge clk);
        peek_addr = addr;
        @(posedge clk); // peek is stable while the core is idle
        compare(name, exp, peek_data);
    endtask

    task automatic alu_ops();
        rv_word_t    a;
        rv_word_t    b;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        rv_word_t    exp[$];
        int          cycles;
        a = $urandom();
        b = $urandom();
        prog.delete();
        load_word(1'b1, 0, a);
        load_word(1'b1, 1, b);
        prog.push_back(load_inst(5'd1, 12'd0));
        prog.push_back(load_inst(5'd2, 12'd4));
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? F3_ADD_SUB : F3_SRL_SRA);
            alt = (k >= 8); // sub and sra
            prog.push_back(r_type(alt ? F7_ALT : F7_BASE, 5'd2, 5'd1, f3, 5'd3));
            prog.push_back(store_inst(5'd3, 12'(64 + 4 * k)));
            exp.push_back(model_op(f3, alt, a, b));
        end
        for (int k = 0; k < 9; k++) begin
            f3  = (k < 8) ? 3'(k) : F3_SRL_SRA;
            alt = (k == 8);
            imm = 12'($urandom());
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                imm[11:5] = alt ? F7_ALT : F7_BASE;
            end
            prog.push_back(i_type(imm, 5'd1, f3, 5'd4, OPC_OP_IMM));
            prog.push_back(store_inst(5'd4, 12'(128 + 4 * k)));
            exp.push_back(model_op(f3, alt, a, {{20{imm[11]}}, imm}));
        end
        prog.push_back(INST_ECALL);
        load_program();
        run_and_wait(cycles);
        foreach (exp[i]) begin
            verify_word($sformatf("alu op %0d", i), (i < 10) ? 16 + i : 22 + i, exp[i]);
        end
    endtask

    task automatic shift_compare();
        rv_word_t   neg;
        rv_word_t   pos;
        logic [4:0] sh;
        int         cycles;
        neg = $urandom() | 32'h8000_0000;
        pos = $urandom() & 32'h7fff_ffff;
        sh  = 5'($urandom_range(31, 1));
        prog.delete();
        load_word(1'b1, 0, neg);
        load_word(1'b1, 1, {27'd0, sh});
        load_word(1'b1, 2, pos);
        prog.push_back(load_inst(5'd1, 12'd0));
        prog.push_back(load_inst(5'd2, 12'd4));
        prog.push_back(load_inst(5'd3, 12'd8));
        prog.push_back(r_type(F7_ALT, 5'd2, 5'd1, F3_SRL_SRA, 5'd4));
        prog.push_back(store_inst(5'd4, 12'd64));
        prog.push_back(i_type({F7_ALT, sh}, 5'd1, F3_SRL_SRA, 5'd5, OPC_OP_IMM));
        prog.push_back(store_inst(5'd5, 12'd68));
        prog.push_back(r_type(F7_BASE, 5'd3, 5'd1, F3_SLT, 5'd6));
        prog.push_back(r_type(F7_BASE, 5'd3, 5'd1, F3_SLTU, 5'd7));
        prog.push_back(r_type(F7_BASE, 5'd1, 5'd3, F3_SLT, 5'd8));
        prog.push_back(r_type(F7_BASE, 5'd1, 5'd3, F3_SLTU, 5'd9));
        prog.push_back(store_inst(5'd6, 12'd72));
        prog.push_back(store_inst(5'd7, 12'd76));
        prog.push_back(store_inst(5'd8, 12'd80));
        prog.push_back(store_inst(5'd9, 12'd84));
        prog.push_back(INST_ECALL);
        load_program();
        run_and_wait(cycles);
        verify_word("sra", 16, ~(~neg >> sh)); // sign bits shifted in
        verify_word("srai", 17, ~(~neg >> sh));
        verify_word("slt neg<pos", 18, 32'd1);
        verify_word("sltu neg<pos", 19, 32'd0);
        verify_word("slt pos<neg", 20, 32'd0);
        verify_word("sltu pos<neg", 21, 32'd1);
    endtask

    task automatic branches();
        rv_word_t   pa[3];
        rv_word_t   pb[3];
        logic [2:0] br[6];
        rv_word_t   exp[$];
        int         k;
        int         cycles;
        pa = '{32'd5, 32'hffff_fffd, 32'd7}; // equal pair then sign differs both ways
        pb = '{32'd5, 32'd7, 32'hffff_fffd};
        br = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        prog.delete();
        for (int j = 0; j < 3; j++) begin
            load_word(1'b1, 2 * j, pa[j]);
            load_word(1'b1, 2 * j + 1, pb[j]);
            prog.push_back(load_inst(5'(10 + 2 * j), 12'(8 * j)));
            prog.push_back(load_inst(5'(11 + 2 * j), 12'(8 * j + 4)));
        end
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 3; j++) begin
                k = 3 * i + j;
                prog.push_back(b_type(13'd12, 5'(11 + 2 * j), 5'(10 + 2 * j), br[i]));
                prog.push_back(i_type(12'h15a, 5'd0, F3_ADD_SUB, 5'd5, OPC_OP_IMM));
                prog.push_back(j_type(21'd8, 5'd0));
                prog.push_back(i_type(12'h2a5, 5'd0, F3_ADD_SUB, 5'd5, OPC_OP_IMM));
                prog.push_back(store_inst(5'd5, 12'(64 + 4 * k)));
                exp.push_back(branch_rule(br[i], pa[j], pb[j]) ? 32'h2a5 : 32'h15a);
            end
        end
        prog.push_back(INST_ECALL);
        load_program();
        run_and_wait(cycles);
        foreach (exp[i]) begin
            verify_word($sformatf("branch %0d pair %0d", i / 3, i % 3), 16 + i, exp[i]);
        end
    endtask

    task automatic jumps();
        rv_word_t fill[4];
        int       cycles;
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            fill[i] = $urandom() | 32'h1;
            load_word(1'b1, 16 + i, fill[i]);
        end
        prog.push_back(j_type(21'd12, 5'd1));                 // 0 jumps to 12
        prog.push_back(store_inst(5'd0, 12'd68));
        prog.push_back(store_inst(5'd0, 12'd68));
        prog.push_back(store_inst(5'd1, 12'd64));             // 12
        prog.push_back(i_type(12'd32, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM));
        prog.push_back(i_type(12'd5, 5'd2, F3_JALR, 5'd3, OPC_JALR)); // 20 jumps to 37 & ~1
        prog.push_back(store_inst(5'd0, 12'd72));
        prog.push_back(store_inst(5'd0, 12'd72));
        prog.push_back(store_inst(5'd0, 12'd72));
        prog.push_back(store_inst(5'd3, 12'd76));             // 36
        prog.push_back(INST_ECALL);
        load_program();
        run_and_wait(cycles);
        verify_word("jal link", 16, 32'd4);
        verify_word("jal skipped", 17, fill[1]);
        verify_word("jalr skipped", 18, fill[2]);
        verify_word("jalr link", 19, 32'd24);
    endtask

    task automatic x0_and_halt();
        rv_word_t fill[4];
        int       cycles;
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            fill[i] = $urandom() | 32'h1;
        end
        load_word(1'b1, 0, fill[0]);
        load_word(1'b1, 16, fill[1]);
        load_word(1'b1, 17, fill[2]);
        load_word(1'b1, 18, fill[3]);
        prog.push_back(i_type(12'h5a5, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM));
        prog.push_back(store_inst(5'd0, 12'd64));
        prog.push_back(load_inst(5'd0, 12'd0));
        prog.push_back(store_inst(5'd0, 12'd68));
        prog.push_back(INST_ECALL);
        prog.push_back(i_type(12'h321, 5'd0, F3_ADD_SUB, 5'd7, OPC_OP_IMM));
        prog.push_back(store_inst(5'd7, 12'd72));
        load_program();
        run_and_wait(cycles);
        compare("halt latency", 32'd5, cycles); // 4 instructions before ecall
        compare("running after halt", 32'd0, {31'd0, running});
        verify_word("addi to x0", 16, 32'd0);
        verify_word("lw to x0", 17, 32'd0);
        verify_word("after ecall", 18, fill[3]);
        // second run with the same program
        load_word(1'b1, 16, fill[2]);
        run_and_wait(cycles);
        compare("restart latency", 32'd5, cycles);
        verify_word("restart from pc 0", 16, 32'd0);
        verify_word("after ecall rerun", 18, fill[3]);
    endtask

    initial begin
        void'($urandom(32'h49fd_66ce));
        rst_n     = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_sel  = 1'b0;
        load_addr = '0;
        load_data = '0;
        peek_addr = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        alu_ops();
        shift_compare();
        branches();
        jumps();
        x0_and_halt();
        if (u_dut.u_core.u_sva.fail_count != 0) begin
            $display("%0d assertion failures in the core", u_dut.u_core.u_sva.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- filelist.f
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/rv_mem.sv
hw/rv_fetch.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_core.sv
hw/rv_soc_top.sv
test/rv_soc_assertions.sv
test/tb_rv_soc.sv
